/* rtl/tile_consts.svh */
/* geometry and memory widths for the scroll layer
   buffer entries above the visible line width are scratch for the fine scroll
   the unmapped colour is a 4-bit literal */
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// visible pixels per scan line
`define TILE_LINE_W 448

// entries per line buffer bank
`define TILE_BUF_DEPTH 512
`define TILE_BUF_AW 9

// word address widths of the two memories
`define TILE_VRAM_AW 17
`define TILE_ROM_AW 20

// shown for tiles whose code falls outside the bank mask
`define TILE_UNMAPPED_COLOUR 4'hf

`endif

/* rtl/tile_pkg.sv */
/* shared types for the scroll layer
   line_px_t keeps the palette above the colour, as the line buffer stores it
   layer_cfg_t size must be one-hot while a fetch runs */
`include "tile_consts.svh"

package tile_pkg;

    // second VRAM word of a tile map entry
    typedef struct packed {
        logic [8:0] rsvd;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] colour;
    } line_px_t;

    // one write into the line buffer
    typedef struct packed {
        logic                    wr;
        logic                    bank;
        logic [`TILE_BUF_AW-1:0] addr;
        line_px_t                data;
    } buf_write_t;

    typedef struct packed {
        logic [2:0]  size;          // bit 0 8x8, bit 1 16x16, bit 2 32x32
        logic [15:0] vram_base;
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [3:0]  bank_offset;
        logic [3:0]  bank_mask;
    } layer_cfg_t;

endpackage

/* rtl/tile_line_fetch.sv */
/* renders one scan line of a scroll layer into the bank given by wbank
   cfg and vrender must stay stable from start until done
   each address change is followed by one dead cycle before ok is sampled */
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_line_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  tile_pkg::layer_cfg_t     cfg,
    input  logic [8:0]               vrender,
    input  logic                     start,
    input  logic                     stop,
    input  logic                     wbank,
    input  logic [15:0]              vram_data,
    input  logic                     vram_ok,
    input  logic [31:0]              rom_data,
    input  logic                     rom_ok,
    output logic                     done,
    output logic [`TILE_VRAM_AW-1:0] vram_addr,
    output logic                     vram_cs,
    output logic [`TILE_ROM_AW-1:0]  rom_addr,
    output logic                     rom_half,
    output logic                     rom_cs,
    output tile_pkg::buf_write_t     bw
);
    import tile_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_MAP,
        S_CODE_W,
        S_CODE,
        S_ATTR_W,
        S_ATTR,
        S_ROM,
        S_ROM_W,
        S_WORD,
        S_PIX
    } fetch_st_t;

    fetch_st_t st;

    logic [10:0] vn;            // line within the map
    logic [10:0] hn;            // left edge of the current tile
    logic [15:0] code;
    tile_attr_t  attr;
    logic [31:0] pxl;
    logic [2:0]  pix_cnt;
    logic [1:0]  word_k;        // word of the tile row, from the left
    logic [8:0]  waddr;         // next buffer address

    logic        wr_q;
    logic        wr_bank_q;
    logic [8:0]  wr_addr_q;
    line_px_t    wr_px_q;

    logic [5:0]  tile_w;
    logic [4:0]  fine_mask;
    logic [1:0]  word_mask;
    logic [11:0] scan;
    logic [`TILE_VRAM_AW-1:0] map_addr;
    logic [15:0] code2;
    logic        unmapped;
    logic [4:0]  row;
    logic [1:0]  flip_mask;
    logic [1:0]  j_next;
    logic        last_word;
    logic        last_px;
    logic [3:0]  px_colour;
    logic [`TILE_ROM_AW-1:0] rom_row;
    logic [`TILE_ROM_AW-1:0] rom_first;

    assign tile_w    = {cfg.size, 3'b000};
    assign fine_mask = tile_w[4:0] - 5'd1;   // 32 wraps to 31
    assign word_mask = {cfg.size[2], cfg.size[2] | cfg.size[1]};

    // tile map scan order, high row bits, column, low row bits
    always_comb begin
        case (cfg.size)
            3'b001:  scan = {vn[8], hn[8:3], vn[7:3]};
            3'b010:  scan = {vn[9:8], hn[9:4], vn[7:4]};
            3'b100:  scan = {vn[10:8], hn[10:5], vn[7:5]};
            default: scan = 12'd0;
        endcase
    end

    assign map_addr = {cfg.vram_base[9:1], 8'd0} + {4'd0, scan, 1'b0};

    assign code2    = {code[15:12] & cfg.bank_mask, code[11:0]};
    assign unmapped = |(code[15:12] & ~cfg.bank_mask);

    assign row       = vn[4:0] ^ {5{attr.vflip}};
    assign flip_mask = {2{attr.hflip}} & word_mask;  // first word with hflip is the last one
    assign j_next    = (word_k + 2'd1) ^ flip_mask;
    assign last_word = (word_k == word_mask);
    assign last_px   = (waddr == 9'(`TILE_LINE_W - 1));

    always_comb begin
        case (cfg.size)
            3'b001:  rom_row = {1'b0, code2, row[2:0]};
            3'b010:  rom_row = {code2, row[3:0]};
            3'b100:  rom_row = {code2[13:0], row, flip_mask[1]};
            default: rom_row = '0;
        endcase
    end

    assign rom_first = {cfg.bank_offset, 16'd0} | rom_row;

    // planar pixel from the edge of the shift register
    always_comb begin
        if (unmapped)
            px_colour = `TILE_UNMAPPED_COLOUR;
        else if (attr.hflip)
            px_colour = {pxl[24], pxl[16], pxl[8], pxl[0]};
        else
            px_colour = {pxl[31], pxl[23], pxl[15], pxl[7]};
    end

    assign bw = '{wr: wr_q, bank: wr_bank_q, addr: wr_addr_q, data: wr_px_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= S_IDLE;
            done    <= 1'b0;
            vram_cs <= 1'b0;
            rom_cs  <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            done <= 1'b0;
            wr_q <= 1'b0;
            case (st)
                S_IDLE:   if (start) st <= S_MAP;
                S_MAP: begin
                    vram_cs <= 1'b1;
                    st      <= S_CODE_W;
                end
                S_CODE_W: st <= S_CODE;
                S_CODE:   if (vram_ok) st <= S_ATTR_W;
                S_ATTR_W: st <= S_ATTR;
                S_ATTR:   if (vram_ok) st <= S_ROM;
                S_ROM: begin
                    rom_cs <= 1'b1;
                    st     <= S_ROM_W;
                end
                S_ROM_W:  st <= S_WORD;
                S_WORD:   if (rom_ok) st <= S_PIX;
                S_PIX: begin
                    wr_q <= 1'b1;
                    if (last_px) begin
                        done    <= 1'b1;
                        vram_cs <= 1'b0;
                        rom_cs  <= 1'b0;
                        st      <= S_IDLE;
                    end else if (pix_cnt == 3'd7) begin
                        st <= last_word ? S_MAP : S_ROM_W;
                    end
                end
                default:  st <= S_IDLE;
            endcase
            if (stop) begin     // abandon the rest of the line
                done    <= 1'b1;
                vram_cs <= 1'b0;
                rom_cs  <= 1'b0;
                st      <= S_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (st)
            S_IDLE: begin
                vn    <= cfg.vpos[10:0] + {2'b00, vrender};
                hn    <= cfg.hpos[10:0] & ~{6'd0, fine_mask};
                waddr <= 9'd0 - {4'd0, cfg.hpos[4:0] & fine_mask};
            end
            S_MAP:  vram_addr <= map_addr;
            S_CODE: if (vram_ok) begin
                code      <= vram_data;
                vram_addr <= vram_addr + 1'b1;  // attribute word follows
            end
            S_ATTR: if (vram_ok) attr <= vram_data;
            S_ROM: begin
                rom_addr <= rom_first;
                rom_half <= flip_mask[0];
                word_k   <= 2'd0;
                hn       <= hn + {5'd0, tile_w};
            end
            S_WORD: if (rom_ok) begin
                pxl     <= rom_data;
                pix_cnt <= 3'd0;
            end
            S_PIX: begin
                wr_bank_q <= wbank;
                wr_addr_q <= waddr;
                wr_px_q   <= '{pal: attr.pal, colour: px_colour};
                waddr     <= waddr + 9'd1;
                pxl       <= attr.hflip ? pxl >> 1 : pxl << 1;
                pix_cnt   <= pix_cnt + 3'd1;
                if (pix_cnt == 3'd7 && !last_word) begin
                    word_k   <= word_k + 2'd1;
                    rom_half <= j_next[0];
                    if (cfg.size[2])
                        rom_addr[0] <= j_next[1];
                end
            end
            default: ;
        endcase
    end

    // the tile size decides the scan and the ROM layout for the whole line
    a_size_onehot: assert property (@(posedge clk) disable iff (rst)
        (st != S_IDLE) |-> $onehot(cfg.size));

    a_rom_idle: assert property (@(posedge clk) disable iff (rst)
        (st == S_IDLE) |-> !rom_cs);

endmodule

/* rtl/line_buffer.sv */
/* two line banks with one write port and one registered read port
   the fetcher writes one bank while the scanout reads the other
   read data follows the address by one cycle */
`timescale 1ns/1ps
`include "tile_consts.svh"

module line_buffer (
    input  logic                    clk,
    input  tile_pkg::buf_write_t    bw,
    input  logic                    rbank,
    input  logic [`TILE_BUF_AW-1:0] raddr,
    output tile_pkg::line_px_t      rdata
);
    import tile_pkg::*;

    // bank select is the top address bit
    line_px_t mem [2*`TILE_BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (bw.wr)
            mem[{bw.bank, bw.addr}] <= bw.data;
    end

    always_ff @(posedge clk) begin
        rdata <= mem[{rbank, raddr}];
    end

    // bank ownership is split between fetcher and scanout
    a_bank_apart: assert property (@(posedge clk)
        bw.wr |-> (bw.bank != rbank));

endmodule

/* rtl/line_scanout.sv */
/* reads the displayed bank one pixel per pix_en
   line_start swaps banks and must not come while a fetch runs
   pixel and pix_valid follow pix_en by two cycles, no back-pressure */
`timescale 1ns/1ps
`include "tile_consts.svh"

module line_scanout (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    line_start,
    input  logic                    pix_en,
    input  tile_pkg::line_px_t      rdata,
    output logic                    rbank,
    output logic [`TILE_BUF_AW-1:0] raddr,
    output tile_pkg::line_px_t      pixel,
    output logic                    pix_valid
);
    logic issue;
    logic rd_v;     // read in flight in the buffer

    // pixels past the visible width are dropped
    assign issue = pix_en && !line_start && (raddr < 9'(`TILE_LINE_W));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rbank     <= 1'b0;
            raddr     <= '0;
            rd_v      <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            if (line_start) begin
                rbank <= ~rbank;
                raddr <= '0;
            end else if (issue) begin
                raddr <= raddr + 1'b1;
            end
            rd_v      <= issue;
            pix_valid <= rd_v;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_v)
            pixel <= rdata;     // buffer output for the previous raddr
    end

endmodule

/* rtl/tile_layer_top.sv */
/* one scroll layer, fetcher, line buffer and scanout
   the fetcher fills the bank that the scanout is not showing
   memories answer through their ok levels with any latency */
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_layer_top (
    input  logic                     clk,
    input  logic                     rst,
    input  tile_pkg::layer_cfg_t     cfg,
    input  logic [8:0]               vrender,
    input  logic                     start,
    input  logic                     stop,
    output logic                     done,
    output logic [`TILE_VRAM_AW-1:0] vram_addr,
    output logic                     vram_cs,
    input  logic [15:0]              vram_data,
    input  logic                     vram_ok,
    output logic [`TILE_ROM_AW-1:0]  rom_addr,
    output logic                     rom_half,
    output logic                     rom_cs,
    input  logic [31:0]              rom_data,
    input  logic                     rom_ok,
    input  logic                     line_start,
    input  logic                     pix_en,
    output tile_pkg::line_px_t       pixel,
    output logic                     pix_valid
);
    import tile_pkg::*;

    buf_write_t              bw;
    logic                    rbank;
    logic [`TILE_BUF_AW-1:0] raddr;
    line_px_t                rdata;

    tile_line_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .vrender   (vrender),
        .start     (start),
        .stop      (stop),
        .wbank     (~rbank),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .done      (done),
        .vram_addr (vram_addr),
        .vram_cs   (vram_cs),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_cs    (rom_cs),
        .bw        (bw)
    );

    line_buffer u_buf (
        .clk   (clk),
        .bw    (bw),
        .rbank (rbank),
        .raddr (raddr),
        .rdata (rdata)
    );

    line_scanout u_scan (
        .clk        (clk),
        .rst        (rst),
        .line_start (line_start),
        .pix_en     (pix_en),
        .rdata      (rdata),
        .rbank      (rbank),
        .raddr      (raddr),
        .pixel      (pixel),
        .pix_valid  (pix_valid)
    );

endmodule

/* bench/tile_mem_model.sv */
/* VRAM and ROM responders for the scroll layer bench
   ok rises 0 to 3 cycles after a new address, data is a hash of the address
   ok is dropped one cycle after the address changes */
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_mem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`TILE_VRAM_AW-1:0] vram_addr,
    input  logic                     vram_cs,
    output logic [15:0]              vram_data,
    output logic                     vram_ok,
    input  logic [`TILE_ROM_AW-1:0]  rom_addr,
    input  logic                     rom_half,
    input  logic                     rom_cs,
    output logic [31:0]              rom_data,
    output logic                     rom_ok
);
    integer seed = 32'h71ac;

    logic [`TILE_VRAM_AW-1:0] vram_last;
    logic [`TILE_ROM_AW:0]    rom_last;     // address with the half bit
    logic [1:0]               vram_wait;
    logic [1:0]               rom_wait;

    function automatic logic [15:0] vram_word(input logic [`TILE_VRAM_AW-1:0] a);
        logic [31:0] x;
        x = {15'd0, a} * 32'h9e3779b1;
        return x[31:16] ^ x[15:0];
    endfunction

    function automatic logic [31:0] rom_word(input logic [`TILE_ROM_AW-1:0] a,
                                             input logic half);
        logic [31:0] x;
        x = {11'd0, a, half} * 32'h85ebca6b;
        x = x ^ (x >> 15);
        x = x * 32'hc2b2ae35;
        return x ^ (x >> 13);
    endfunction

    assign vram_data = vram_word(vram_addr);
    assign rom_data  = rom_word(rom_addr, rom_half);

    always @(posedge clk or posedge rst) begin
        logic [31:0] r;
        if (rst) begin
            vram_ok   <= 1'b0;
            rom_ok    <= 1'b0;
            vram_wait <= 2'd0;
            rom_wait  <= 2'd0;
            vram_last <= '0;
            rom_last  <= '0;
        end else begin
            if (!vram_cs || vram_addr != vram_last) begin   // new request
                r = $random(seed);
                vram_last <= vram_addr;
                vram_ok   <= 1'b0;
                vram_wait <= r[1:0];
            end else if (vram_wait == 2'd0) vram_ok <= 1'b1;
            else vram_wait <= vram_wait - 2'd1;
            if (!rom_cs || {rom_addr, rom_half} != rom_last) begin
                r = $random(seed);
                rom_last <= {rom_addr, rom_half};
                rom_ok   <= 1'b0;
                rom_wait <= r[1:0];
            end else if (rom_wait == 2'd0) rom_ok <= 1'b1;
            else rom_wait <= rom_wait - 2'd1;
        end
    end

endmodule

/* bench/tile_layer_tb.sv */
/* drives whole lines through the scroll layer and checks every pixel
   expected pixels come from the tile fetch rule and the memory hashes
   the first error ends the run */
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_layer_tb;
    import tile_pkg::*;

    localparam int N_LINES        = 14;
    localparam int CYCLES_PER_LINE = 4000;  // fetch plus scanout with gaps

    logic clk = 1'b0;
    logic rst = 1'b1;
    layer_cfg_t cfg = '0;
    logic [8:0] vrender = '0;
    logic start = 1'b0;
    logic stop = 1'b0;
    logic line_start = 1'b0;
    logic pix_en = 1'b0;
    logic done, vram_cs, vram_ok, rom_half, rom_cs, rom_ok, pix_valid;
    logic [`TILE_VRAM_AW-1:0] vram_addr;
    logic [`TILE_ROM_AW-1:0]  rom_addr;
    logic [15:0] vram_data;
    logic [31:0] rom_data;
    line_px_t pixel;

    integer seed = 32'h71ac;
    layer_cfg_t cur_cfg = '0;       // cfg of the line being shown
    logic [8:0] cur_vr = '0;
    int exp_x = 0;
    int en_cnt = 0;                 // pix_en strobes since line_start
    logic [1:0] en_hist;

    always #10 clk = ~clk;

    tile_layer_top u_dut (.clk(clk), .rst(rst), .cfg(cfg), .vrender(vrender), .start(start),
        .stop(stop), .done(done), .vram_addr(vram_addr), .vram_cs(vram_cs),
        .vram_data(vram_data), .vram_ok(vram_ok), .rom_addr(rom_addr), .rom_half(rom_half),
        .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok), .line_start(line_start),
        .pix_en(pix_en), .pixel(pixel), .pix_valid(pix_valid));

    tile_mem_model u_mem (.clk(clk), .rst(rst), .vram_addr(vram_addr), .vram_cs(vram_cs),
        .vram_data(vram_data), .vram_ok(vram_ok), .rom_addr(rom_addr), .rom_half(rom_half),
        .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok));

    task automatic check_px(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h (x %0d)", $time, what, got, exp,
                     exp_x);
            $display("tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    // pixel at screen x of line vr by the tile fetch rule
    function automatic line_px_t expected_px(input layer_cfg_t c, input logic [8:0] vr,
                                             input int x);
        int          t;             // tile size in pixels
        int          lo;            // low row bits of the map index
        int          v;
        int          h;
        int          trow;
        int          tcol;
        int          idx;
        int          r;
        int          k;
        int          j;
        int          i;
        logic [16:0] a;
        logic [15:0] code;
        logic [15:0] code2;
        tile_attr_t  at;
        logic        unm;
        logic [19:0] ra;
        logic [31:0] w;
        logic [3:0]  col;
        t    = c.size[0] ? 8 : (c.size[1] ? 16 : 32);
        lo   = c.size[0] ? 5 : (c.size[1] ? 4 : 3);
        v    = int'(c.vpos) + int'(vr);
        h    = int'(c.hpos) + x;
        trow = v / t;
        tcol = h / t;
        idx  = ((trow >> lo) % (1 << (6 - lo))) * (1 << (6 + lo))
               + (tcol % 64) * (1 << lo) + trow % (1 << lo);
        a    = 17'(int'(c.vram_base[9:1]) * 256 + 2 * idx);
        code = u_mem.vram_word(a);
        at   = u_mem.vram_word(a + 17'd1);
        unm   = (code[15:12] | c.bank_mask) != c.bank_mask;
        code2 = code & {c.bank_mask, 12'hfff};
        r = v % t;
        if (at.vflip)
            r = t - 1 - r;
        k = (h % t) / 8;
        j = at.hflip ? (t / 8 - 1 - k) : k;
        case (t)
            8:       ra = 20'(int'(code2) * 8 + r);
            16:      ra = 20'(int'(code2) * 16 + r);
            default: ra = 20'((int'(code2) % 16384) * 64 + r * 2 + j / 2);
        endcase
        ra = ra | {c.bank_offset, 16'd0};
        w = u_mem.rom_word(ra, j[0]);
        i = h % 8;
        if (unm)
            col = 4'hf;
        else if (at.hflip)
            col = {w[24 + i], w[16 + i], w[8 + i], w[i]};
        else
            col = {w[31 - i], w[23 - i], w[15 - i], w[7 - i]};
        return '{pal: at.pal, colour: col};
    endfunction

    // pix_valid two cycles after each pix_en that falls inside the line
    always @(posedge clk) begin
        if (rst) begin
            en_hist <= 2'b00;
            en_cnt  = 0;
        end else begin
            en_hist <= {en_hist[0], (pix_en && (en_cnt < `TILE_LINE_W))};
            if (line_start)
                en_cnt = 0;
            else if (pix_en && (en_cnt < `TILE_LINE_W))
                en_cnt = en_cnt + 1;
            check_px("pix_valid timing", 32'(pix_valid), 32'(en_hist[1]));
            if (pix_valid) begin
                check_px("pixel", 32'(pixel), 32'(expected_px(cur_cfg, cur_vr, exp_x)));
                exp_x = exp_x + 1;
            end
        end
    end

    initial begin
        repeat (N_LINES * CYCLES_PER_LINE) @(posedge clk);
        $display("timeout, the DUT stopped answering");
        $display("tests failed");
        $fatal(1, "watchdog");
    end

    function automatic layer_cfg_t make_cfg(input logic [2:0] size, input logic [15:0] base,
            input logic [15:0] hpos, input logic [15:0] vpos, input logic [3:0] off,
            input logic [3:0] mask);
        return '{size: size, vram_base: base, hpos: hpos, vpos: vpos,
                 bank_offset: off, bank_mask: mask};
    endfunction

    task automatic pulse_start_line;
        @(posedge clk) line_start <= 1'b1;
        @(posedge clk) line_start <= 1'b0;
    endtask

    task automatic run_line(input layer_cfg_t c, input logic [8:0] vr);
        logic [31:0] r;
        @(posedge clk);
        cfg     <= c;
        vrender <= vr;
        pulse_start_line();
        @(posedge clk) start <= 1'b1;
        @(posedge clk) start <= 1'b0;
        while (!done) @(posedge clk);
        cur_cfg = c;
        cur_vr  = vr;
        exp_x   = 0;
        pulse_start_line();
        for (int n = 0; n < `TILE_LINE_W; n++) begin
            r = $random(seed);
            @(posedge clk) pix_en <= 1'b1;
            if (r[1:0] != 2'd0) begin       // a zero gap gives back-to-back strobes
                @(posedge clk) pix_en <= 1'b0;
                repeat (r[1:0] - 2'd1) @(posedge clk);
            end
        end
        // strobes past the line width yield no pixel
        repeat (3) @(posedge clk) pix_en <= 1'b1;
        @(posedge clk) pix_en <= 1'b0;
        repeat (4) @(posedge clk);
        check_px("pixel count", 32'(exp_x), 32'(`TILE_LINE_W));
    endtask

    task automatic stop_fetch(input layer_cfg_t c);
        logic seen;
        @(posedge clk);
        cfg <= c;
        @(posedge clk) start <= 1'b1;
        @(posedge clk) start <= 1'b0;
        repeat (30) @(posedge clk);
        stop <= 1'b1;
        @(posedge clk) stop <= 1'b0;
        seen = 1'b0;
        repeat (2) begin
            @(posedge clk);
            if (done) seen = 1'b1;
        end
        check_px("done after stop", 32'(seen), 32'd1);
        check_px("vram_cs after stop", 32'(vram_cs), 32'd0);
        check_px("rom_cs after stop", 32'(rom_cs), 32'd0);
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // 8x8 without scroll
        run_line(make_cfg(3'b001, 16'h0400, 16'd0, 16'd0, 4'd0, 4'hf), 9'd0);
        run_line(make_cfg(3'b001, 16'h0400, 16'd0, 16'd0, 4'd0, 4'hf), 9'd13);
        // larger tiles with fine scroll
        run_line(make_cfg(3'b010, 16'h0800, 16'd5, 16'd3, 4'd0, 4'hf), 9'd0);
        run_line(make_cfg(3'b010, 16'h0800, 16'd27, 16'd3, 4'd0, 4'hf), 9'd77);
        run_line(make_cfg(3'b010, 16'h0800, 16'd211, 16'd40, 4'd0, 4'hf), 9'd239);
        run_line(make_cfg(3'b100, 16'h0c02, 16'd9, 16'd0, 4'd0, 4'hf), 9'd1);
        run_line(make_cfg(3'b100, 16'h0c02, 16'd30, 16'd17, 4'd0, 4'hf), 9'd100);
        run_line(make_cfg(3'b100, 16'h0c02, 16'd1021, 16'd500, 4'd0, 4'hf), 9'd255);
        // flipped tiles appear across these lines too
        run_line(make_cfg(3'b001, 16'h1234, 16'd3, 16'd7, 4'd0, 4'hf), 9'd50);
        run_line(make_cfg(3'b100, 16'h1234, 16'd14, 16'd31, 4'd0, 4'hf), 9'd31);
        // bank mapping
        run_line(make_cfg(3'b001, 16'h0400, 16'd2, 16'd0, 4'h5, 4'h3), 9'd20);
        run_line(make_cfg(3'b010, 16'h0400, 16'd6, 16'd9, 4'h5, 4'h3), 9'd61);
        // stop, then a normal line
        stop_fetch(make_cfg(3'b001, 16'h0400, 16'd0, 16'd0, 4'd0, 4'hf));
        run_line(make_cfg(3'b010, 16'h0600, 16'd11, 16'd2, 4'd0, 4'hf), 9'd8);
        $display("all tests passed");
        $finish;
    end

endmodule

/* tile_layer_top.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/tile_line_fetch.sv
rtl/line_buffer.sv
rtl/line_scanout.sv
rtl/tile_layer_top.sv
bench/tile_mem_model.sv
bench/tile_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scroll layer testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f tile_layer_top.f \
    --top-module tile_layer_tb \
    -o tile_layer_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/tile_layer_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
